// ==== all.f ====
source/gamePkg.sv
source/keyDecoder.sv
source/matchControl.sv
source/playerMotion.sv
source/arenaTracker.sv
source/gameLogic.sv
test/gameChecker.sv
test/gameLogicTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the arena testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module gameLogicTb -o simv &&
result="$(./obj_dir/simv)" &&
echo "$result" &&
echo "$result" | grep -qx "PASS: all tests" ||
{ echo "Simulation did not pass" >&2; exit 1; }

// ==== source/arenaTracker.sv ====
/* Both player positions with map bounds and the no-overlap rule */
`timescale 1ns/10ps

module arenaTracker (
	input logic VGA_VS,
	input logic rstN,
	input logic signed [gamePkg::coordWidth-1:0] stepXOne,
	input logic signed [gamePkg::coordWidth-1:0] stepYOne,
	input logic signed [gamePkg::coordWidth-1:0] stepXTwo,
	input logic signed [gamePkg::coordWidth-1:0] stepYTwo,
	output logic [gamePkg::coordWidth-1:0] xOne,
	output logic [gamePkg::coordWidth-1:0] yOne,
	output logic [gamePkg::coordWidth-1:0] xTwo,
	output logic [gamePkg::coordWidth-1:0] yTwo
);
	import gamePkg::*;

	logic [coordWidth-1:0] candXOne;
	logic [coordWidth-1:0] candYOne;
	logic [coordWidth-1:0] candXTwo;
	logic [coordWidth-1:0] candYTwo;
	logic [coordWidth-1:0] distX;
	logic [coordWidth-1:0] distY;
	logic blocked;

	// Two's complement add, positions never sit near the wrap point
	assign candXOne = xOne + $unsigned(stepXOne);
	assign candYOne = yOne + $unsigned(stepYOne);
	assign candXTwo = xTwo + $unsigned(stepXTwo);
	assign candYTwo = yTwo + $unsigned(stepYTwo);

	assign distX = (candXOne > candXTwo) ? candXOne - candXTwo : candXTwo - candXOne;
	assign distY = (candYOne > candYTwo) ? candYOne - candYTwo : candYTwo - candYOne;

	// Too close on both axes freezes both players
	assign blocked = (distX < minSeparation) && (distY < minSeparation);

	always_ff @(posedge VGA_VS)
	begin
		if (!rstN)
		begin
			xOne <= xStartOne;
			yOne <= yStartOne;
			xTwo <= xStartTwo;
			yTwo <= yStartTwo;
		end
		else if (!blocked)
		begin
			if (candXOne >= xMin && candXOne <= xMax)
				xOne <= candXOne;
			if (candYOne >= yMin && candYOne <= yMax)
				yOne <= candYOne;
			if (candXTwo >= xMin && candXTwo <= xMax)
				xTwo <= candXTwo;
			if (candYTwo >= yMin && candYTwo <= yMax)
				yTwo <= candYTwo;
		end
	end

	assert property (@(posedge VGA_VS) disable iff (!rstN)
		xOne >= xMin && xOne <= xMax && xTwo >= xMin && xTwo <= xMax);
	assert property (@(posedge VGA_VS) disable iff (!rstN)
		yOne >= yMin && yOne <= yMax && yTwo >= yMin && yTwo <= yMax);

endmodule

// ==== source/gameLogic.sv ====
/* Arena top level, two key decoders, two motion blocks, match FSM and position tracker */
`timescale 1ns/10ps

module gameLogic (
	input logic VGA_VS,
	input logic rstN,
	input logic [gamePkg::keycodeWidth-1:0] keycode,
	input logic [gamePkg::keycodeWidth-1:0] PS2keycode,
	output logic [gamePkg::coordWidth-1:0] xOne,
	output logic [gamePkg::coordWidth-1:0] yOne,
	output logic [gamePkg::coordWidth-1:0] xTwo,
	output logic [gamePkg::coordWidth-1:0] yTwo,
	output logic [gamePkg::dirWidth-1:0] p1dir,
	output logic [gamePkg::dirWidth-1:0] p2dir,
	output logic [gamePkg::stateWidth-1:0] currState,
	output logic isAlt1,
	output logic isAlt2
);
	import gamePkg::*;

	logic readyOne, readyTwo;
	logic northOne, southOne, eastOne, westOne;
	logic aimNorthOne, aimSouthOne, aimEastOne, aimWestOne;
	logic northTwo, southTwo, eastTwo, westTwo;
	logic aimNorthTwo, aimSouthTwo, aimEastTwo, aimWestTwo;
	logic signed [coordWidth-1:0] stepXOne, stepYOne;
	logic signed [coordWidth-1:0] stepXTwo, stepYTwo;

	// Player one on USB
	keyDecoder #(.playerIndex(0)) decoderOne (
		.keys(keycode), .currState(currState), .readyKey(readyOne),
		.north(northOne), .south(southOne), .east(eastOne), .west(westOne),
		.aimNorth(aimNorthOne), .aimSouth(aimSouthOne),
		.aimEast(aimEastOne), .aimWest(aimWestOne)
	);

	// Player two on PS/2
	keyDecoder #(.playerIndex(1)) decoderTwo (
		.keys(PS2keycode), .currState(currState), .readyKey(readyTwo),
		.north(northTwo), .south(southTwo), .east(eastTwo), .west(westTwo),
		.aimNorth(aimNorthTwo), .aimSouth(aimSouthTwo),
		.aimEast(aimEastTwo), .aimWest(aimWestTwo)
	);

	matchControl match (
		.VGA_VS(VGA_VS), .rstN(rstN), .readyOne(readyOne), .readyTwo(readyTwo),
		.currState(currState)
	);

	playerMotion motionOne (
		.VGA_VS(VGA_VS), .rstN(rstN),
		.north(northOne), .south(southOne), .east(eastOne), .west(westOne),
		.aimNorth(aimNorthOne), .aimSouth(aimSouthOne),
		.aimEast(aimEastOne), .aimWest(aimWestOne),
		.stepX(stepXOne), .stepY(stepYOne), .dir(p1dir), .isAlt(isAlt1)
	);

	playerMotion motionTwo (
		.VGA_VS(VGA_VS), .rstN(rstN),
		.north(northTwo), .south(southTwo), .east(eastTwo), .west(westTwo),
		.aimNorth(aimNorthTwo), .aimSouth(aimSouthTwo),
		.aimEast(aimEastTwo), .aimWest(aimWestTwo),
		.stepX(stepXTwo), .stepY(stepYTwo), .dir(p2dir), .isAlt(isAlt2)
	);

	arenaTracker tracker (
		.VGA_VS(VGA_VS), .rstN(rstN),
		.stepXOne(stepXOne), .stepYOne(stepYOne),
		.stepXTwo(stepXTwo), .stepYTwo(stepYTwo),
		.xOne(xOne), .yOne(yOne), .xTwo(xTwo), .yTwo(yTwo)
	);

endmodule

// ==== source/gamePkg.sv ====
/* Shared widths, keyboard codes, direction and state codes,
   map bounds, start positions and animation period */
package gamePkg;

	localparam int keyWidth = 8;
	localparam int rolloverKeys = 4;
	localparam int keycodeWidth = keyWidth * rolloverKeys;
	localparam int coordWidth = 12;
	localparam int dirWidth = 2;
	localparam int stateWidth = 3;
	localparam int animWidth = 5;

	// Facing directions
	localparam logic [dirWidth-1:0] dirNorth = 2'd0;
	localparam logic [dirWidth-1:0] dirSouth = 2'd1;
	localparam logic [dirWidth-1:0] dirEast = 2'd2;
	localparam logic [dirWidth-1:0] dirWest = 2'd3;

	// Match states, also the screen select seen by the renderer
	localparam logic [stateWidth-1:0] stateStart = 3'd0;
	localparam logic [stateWidth-1:0] stateP1Ready = 3'd1;
	localparam logic [stateWidth-1:0] stateP2Ready = 3'd2;
	localparam logic [stateWidth-1:0] statePlay = 3'd3;

	// USB keyboard, player one
	localparam logic [keyWidth-1:0] keyEnterUsb = 8'h28;
	localparam logic [keyWidth-1:0] keyW = 8'h1A;
	localparam logic [keyWidth-1:0] keyA = 8'h04;
	localparam logic [keyWidth-1:0] keyS = 8'h16;
	localparam logic [keyWidth-1:0] keyD = 8'h07;
	localparam logic [keyWidth-1:0] keyUpUsb = 8'h52;
	localparam logic [keyWidth-1:0] keyDownUsb = 8'h51;
	localparam logic [keyWidth-1:0] keyLeftUsb = 8'h50;
	localparam logic [keyWidth-1:0] keyRightUsb = 8'h4F;

	// PS/2 scan codes, player two
	localparam logic [keyWidth-1:0] keyEnterPs2 = 8'h5A;
	localparam logic [keyWidth-1:0] keyWPs2 = 8'h1D;
	localparam logic [keyWidth-1:0] keyAPs2 = 8'h1C;
	localparam logic [keyWidth-1:0] keySPs2 = 8'h1B;
	localparam logic [keyWidth-1:0] keyDPs2 = 8'h23;
	localparam logic [keyWidth-1:0] keyUpPs2 = 8'h75;
	localparam logic [keyWidth-1:0] keyDownPs2 = 8'h72;
	localparam logic [keyWidth-1:0] keyLeftPs2 = 8'h6B;
	localparam logic [keyWidth-1:0] keyRightPs2 = 8'h74;

	localparam logic [coordWidth-1:0] stepSize = 12'd2;
	localparam logic [coordWidth-1:0] xMin = 12'd64;
	localparam logic [coordWidth-1:0] xMax = 12'd3136;
	localparam logic [coordWidth-1:0] yMin = 12'd64;
	localparam logic [coordWidth-1:0] yMax = 12'd2336;
	localparam logic [coordWidth-1:0] minSeparation = 12'd37;

	localparam logic [coordWidth-1:0] xStartOne = 12'd700;
	localparam logic [coordWidth-1:0] yStartOne = 12'd700;
	localparam logic [coordWidth-1:0] xStartTwo = 12'd1500;
	localparam logic [coordWidth-1:0] yStartTwo = 12'd1400;

	// Frames per walking animation half cycle
	localparam logic [animWidth-1:0] animPeriod = 5'd30;

endpackage

// ==== source/keyDecoder.sv ====
/* Four-key rollover decoder for one keyboard, non-ENTER keys masked outside play */
`timescale 1ns/10ps

module keyDecoder #(
	parameter int playerIndex = 0
) (
	input logic [gamePkg::keycodeWidth-1:0] keys,
	input logic [gamePkg::stateWidth-1:0] currState,
	output logic readyKey,
	output logic north,
	output logic south,
	output logic east,
	output logic west,
	output logic aimNorth,
	output logic aimSouth,
	output logic aimEast,
	output logic aimWest
);
	import gamePkg::*;

	// USB codes for player one, PS/2 codes for player two
	localparam logic [keyWidth-1:0] enterCode = (playerIndex == 0) ? keyEnterUsb : keyEnterPs2;
	localparam logic [keyWidth-1:0] northCode = (playerIndex == 0) ? keyW : keyWPs2;
	localparam logic [keyWidth-1:0] westCode = (playerIndex == 0) ? keyA : keyAPs2;
	localparam logic [keyWidth-1:0] southCode = (playerIndex == 0) ? keyS : keySPs2;
	localparam logic [keyWidth-1:0] eastCode = (playerIndex == 0) ? keyD : keyDPs2;
	localparam logic [keyWidth-1:0] upCode = (playerIndex == 0) ? keyUpUsb : keyUpPs2;
	localparam logic [keyWidth-1:0] downCode = (playerIndex == 0) ? keyDownUsb : keyDownPs2;
	localparam logic [keyWidth-1:0] leftCode = (playerIndex == 0) ? keyLeftUsb : keyLeftPs2;
	localparam logic [keyWidth-1:0] rightCode = (playerIndex == 0) ? keyRightUsb : keyRightPs2;

	logic playing;

	// True if any rollover slot holds the code
	function automatic logic keyHeld(
		input logic [keycodeWidth-1:0] word,
		input logic [keyWidth-1:0] code
	);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < rolloverKeys; i++)
		begin
			if (word[i*keyWidth +: keyWidth] == code)
				hit = 1'b1;
		end
		return hit;
	endfunction

	assign playing = (currState == statePlay);

	// ENTER always passes so the match can start
	assign readyKey = keyHeld(keys, enterCode);

	assign north = playing & keyHeld(keys, northCode);
	assign south = playing & keyHeld(keys, southCode);
	assign east = playing & keyHeld(keys, eastCode);
	assign west = playing & keyHeld(keys, westCode);
	assign aimNorth = playing & keyHeld(keys, upCode);
	assign aimSouth = playing & keyHeld(keys, downCode);
	assign aimEast = playing & keyHeld(keys, rightCode);
	assign aimWest = playing & keyHeld(keys, leftCode);

endmodule

// ==== source/matchControl.sv ====
/* Match-start FSM, both ENTER orders lead to play */
`timescale 1ns/10ps

module matchControl (
	input logic VGA_VS,
	input logic rstN,
	input logic readyOne,
	input logic readyTwo,
	output logic [gamePkg::stateWidth-1:0] currState
);
	import gamePkg::*;

	always_ff @(posedge VGA_VS)
	begin
		if (!rstN)
			currState <= stateStart;
		else
		begin
			case (currState)
				stateStart:
				begin
					// Player one wins a tie
					if (readyOne)
						currState <= stateP1Ready;
					else if (readyTwo)
						currState <= stateP2Ready;
				end
				stateP1Ready:
				begin
					if (readyTwo)
						currState <= statePlay;
				end
				stateP2Ready:
				begin
					if (readyOne)
						currState <= statePlay;
				end
				default:
					currState <= currState;
			endcase
		end
	end

	// Only the four match states are ever reached
	assert property (@(posedge VGA_VS) disable iff (!rstN) currState <= statePlay);

endmodule

// ==== source/playerMotion.sv ====
/* Per-player step request, facing register and walking animation bit */
`timescale 1ns/10ps

module playerMotion (
	input logic VGA_VS,
	input logic rstN,
	input logic north,
	input logic south,
	input logic east,
	input logic west,
	input logic aimNorth,
	input logic aimSouth,
	input logic aimEast,
	input logic aimWest,
	output logic signed [gamePkg::coordWidth-1:0] stepX,
	output logic signed [gamePkg::coordWidth-1:0] stepY,
	output logic [gamePkg::dirWidth-1:0] dir,
	output logic isAlt
);
	import gamePkg::*;

	logic [dirWidth-1:0] nextDir;
	logic [animWidth-1:0] animCount;
	logic toggled;
	logic moving;

	// Opposite keys cancel
	always_comb
	begin
		stepX = '0;
		stepY = '0;
		if (east & ~west)
			stepX = stepSize;
		else if (west & ~east)
			stepX = -stepSize;
		if (south & ~north)
			stepY = stepSize;
		else if (north & ~south)
			stepY = -stepSize;
	end

	// Later checks override earlier ones
	always_comb
	begin
		nextDir = dir;
		if (north)
			nextDir = dirNorth;
		if (west)
			nextDir = dirWest;
		if (south)
			nextDir = dirSouth;
		if (east)
			nextDir = dirEast;
		if (aimNorth)
			nextDir = dirNorth;
		if (aimSouth)
			nextDir = dirSouth;
		if (aimWest)
			nextDir = dirWest;
		if (aimEast)
			nextDir = dirEast;
	end

	assign moving = north | south | east | west;

	always_ff @(posedge VGA_VS)
	begin
		if (!rstN)
		begin
			dir <= dirNorth;
			animCount <= '0;
			toggled <= 1'b0;
			isAlt <= 1'b0;
		end
		else
		begin
			dir <= nextDir;
			if (moving)
			begin
				animCount <= (animCount == animPeriod) ? '0 : animCount + 1'b1;
				toggled <= 1'b0;
			end
			// Flip once per wrap, even if the key stays held at the top count
			if (animCount == animPeriod && !toggled)
			begin
				isAlt <= ~isAlt;
				toggled <= 1'b1;
			end
		end
	end

	assert property (@(posedge VGA_VS) disable iff (!rstN) animCount <= animPeriod);

endmodule

// ==== test/gameChecker.sv ====
/* Reference model of match state, facing, animation and positions,
   compared against the DUT outputs every frame */
`timescale 1ns/10ps

module gameChecker (
	input logic VGA_VS,
	input logic rstN,
	input logic [gamePkg::keycodeWidth-1:0] keycode,
	input logic [gamePkg::keycodeWidth-1:0] PS2keycode,
	input logic [gamePkg::coordWidth-1:0] xOne,
	input logic [gamePkg::coordWidth-1:0] yOne,
	input logic [gamePkg::coordWidth-1:0] xTwo,
	input logic [gamePkg::coordWidth-1:0] yTwo,
	input logic [gamePkg::dirWidth-1:0] p1dir,
	input logic [gamePkg::dirWidth-1:0] p2dir,
	input logic [gamePkg::stateWidth-1:0] currState,
	input logic isAlt1,
	input logic isAlt2,
	output int errorCount,
	output int checkCount
);
	import gamePkg::*;

	// Key order W, A, S, D, up, down, left, right
	localparam logic [keyWidth-1:0] usbCodes [8] = '{keyW, keyA, keyS, keyD,
		keyUpUsb, keyDownUsb, keyLeftUsb, keyRightUsb};
	localparam logic [keyWidth-1:0] ps2Codes [8] = '{keyWPs2, keyAPs2, keySPs2, keyDPs2,
		keyUpPs2, keyDownPs2, keyLeftPs2, keyRightPs2};
	localparam logic [dirWidth-1:0] keyDirs [8] = '{dirNorth, dirWest, dirSouth, dirEast,
		dirNorth, dirSouth, dirWest, dirEast};

	logic [stateWidth-1:0] mState;
	logic [dirWidth-1:0] mDir [2];
	logic mAlt [2];
	logic mTog [2];
	int mCnt [2];
	int mX [2];
	int mY [2];
	logic primed = 1'b0;

	function automatic logic held(
		input logic [keycodeWidth-1:0] word,
		input logic [keyWidth-1:0] code
	);
		logic found;
		found = 1'b0;
		for (int i = 0; i < rolloverKeys; i++)
		begin
			if (word[i*keyWidth +: keyWidth] == code)
				found = 1'b1;
		end
		return found;
	endfunction

	// One frame of the model, inputs as seen at the coming edge
	function automatic void stepModel(
		input logic resetN,
		input logic [keycodeWidth-1:0] wordOne,
		input logic [keycodeWidth-1:0] wordTwo
	);
		logic [keycodeWidth-1:0] words [2];
		logic pressed [2][8];
		logic enterOne;
		logic enterTwo;
		logic inPlay;
		logic moving;
		logic oldTog;
		int oldCnt;
		int candX [2];
		int candY [2];
		int distX;
		int distY;
		words[0] = wordOne;
		words[1] = wordTwo;
		if (!resetN)
		begin
			mState = stateStart;
			mX[0] = int'(xStartOne);
			mY[0] = int'(yStartOne);
			mX[1] = int'(xStartTwo);
			mY[1] = int'(yStartTwo);
			for (int p = 0; p < 2; p++)
			begin
				mDir[p] = dirNorth;
				mAlt[p] = 1'b0;
				mTog[p] = 1'b0;
				mCnt[p] = 0;
			end
			return;
		end
		enterOne = held(wordOne, keyEnterUsb);
		enterTwo = held(wordTwo, keyEnterPs2);
		inPlay = (mState == statePlay);
		for (int p = 0; p < 2; p++)
		begin
			for (int k = 0; k < 8; k++)
				pressed[p][k] = inPlay && held(words[p], (p == 0) ? usbCodes[k] : ps2Codes[k]);
			candX[p] = mX[p] + (pressed[p][3] ? int'(stepSize) : 0)
				- (pressed[p][1] ? int'(stepSize) : 0);
			candY[p] = mY[p] + (pressed[p][2] ? int'(stepSize) : 0)
				- (pressed[p][0] ? int'(stepSize) : 0);
		end
		distX = (candX[0] > candX[1]) ? candX[0] - candX[1] : candX[1] - candX[0];
		distY = (candY[0] > candY[1]) ? candY[0] - candY[1] : candY[1] - candY[0];
		if (distX >= int'(minSeparation) || distY >= int'(minSeparation))
		begin
			for (int p = 0; p < 2; p++)
			begin
				if (candX[p] >= int'(xMin) && candX[p] <= int'(xMax))
					mX[p] = candX[p];
				if (candY[p] >= int'(yMin) && candY[p] <= int'(yMax))
					mY[p] = candY[p];
			end
		end
		for (int p = 0; p < 2; p++)
		begin
			// Last matching key wins
			for (int k = 0; k < 8; k++)
			begin
				if (pressed[p][k])
					mDir[p] = keyDirs[k];
			end
			moving = pressed[p][0] | pressed[p][1] | pressed[p][2] | pressed[p][3];
			oldCnt = mCnt[p];
			oldTog = mTog[p];
			if (moving)
			begin
				mCnt[p] = (oldCnt == int'(animPeriod)) ? 0 : oldCnt + 1;
				mTog[p] = 1'b0;
			end
			if (oldCnt == int'(animPeriod) && !oldTog)
			begin
				mAlt[p] = ~mAlt[p];
				mTog[p] = 1'b1;
			end
		end
		case (mState)
			stateStart:
			begin
				if (enterOne)
					mState = stateP1Ready;
				else if (enterTwo)
					mState = stateP2Ready;
			end
			stateP1Ready:
			begin
				if (enterTwo)
					mState = statePlay;
			end
			stateP2Ready:
			begin
				if (enterOne)
					mState = statePlay;
			end
			default:
				mState = mState;
		endcase
	endfunction

	task automatic compareValue(
		input string name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic compareOutputs();
		compareValue("currState", 32'(mState), 32'(currState));
		compareValue("xOne", mX[0], 32'(xOne));
		compareValue("yOne", mY[0], 32'(yOne));
		compareValue("xTwo", mX[1], 32'(xTwo));
		compareValue("yTwo", mY[1], 32'(yTwo));
		compareValue("p1dir", 32'(mDir[0]), 32'(p1dir));
		compareValue("p2dir", 32'(mDir[1]), 32'(p2dir));
		compareValue("isAlt1", 32'(mAlt[0]), 32'(isAlt1));
		compareValue("isAlt2", 32'(mAlt[1]), 32'(isAlt2));
	endtask

	// Outputs and inputs are both settled at the falling edge
	always @(negedge VGA_VS)
	begin
		if (!primed)
		begin
			errorCount = 0;
			checkCount = 0;
		end
		else
			compareOutputs();
		stepModel(rstN, keycode, PS2keycode);
		if (!rstN)
			primed = 1'b1;
	end

endmodule

// ==== test/gameLogicTb.sv ====
/* Arena testbench top with clock, reset, seeded key stimulus,
   DUT, output checker and watchdog */
`timescale 1ns/10ps

module gameLogicTb;
	import gamePkg::*;

	localparam int clockPeriod = 10;
	localparam int resetCycles = 8;
	localparam int preCycles = 20;
	localparam int enterCycles = 12;
	localparam int randomCycles = 400;
	localparam int clampCycles = 900;
	localparam int alignCycles = 25;
	localparam int meetCycles = 250;
	localparam int idleCycles = 4;
	// Two resets and two match starts, then the movement phases
	localparam int totalCycles = 2 * (resetCycles + 1 + enterCycles + randomCycles)
		+ preCycles + clampCycles + alignCycles + meetCycles + idleCycles + 1;
	localparam int marginCycles = 100;

	localparam logic [keyWidth-1:0] usbKeys [8] = '{keyW, keyA, keyS, keyD,
		keyUpUsb, keyDownUsb, keyLeftUsb, keyRightUsb};
	localparam logic [keyWidth-1:0] ps2Keys [8] = '{keyWPs2, keyAPs2, keySPs2, keyDPs2,
		keyUpPs2, keyDownPs2, keyLeftPs2, keyRightPs2};

	logic VGA_VS;
	logic rstN;
	logic [keycodeWidth-1:0] keycode;
	logic [keycodeWidth-1:0] PS2keycode;
	logic [coordWidth-1:0] xOne;
	logic [coordWidth-1:0] yOne;
	logic [coordWidth-1:0] xTwo;
	logic [coordWidth-1:0] yTwo;
	logic [dirWidth-1:0] p1dir;
	logic [dirWidth-1:0] p2dir;
	logic [stateWidth-1:0] currState;
	logic isAlt1;
	logic isAlt2;
	int errorCount;
	int checkCount;
	int seed;

	gameLogic gameLogic_i (
		.VGA_VS(VGA_VS), .rstN(rstN), .keycode(keycode), .PS2keycode(PS2keycode),
		.xOne(xOne), .yOne(yOne), .xTwo(xTwo), .yTwo(yTwo),
		.p1dir(p1dir), .p2dir(p2dir), .currState(currState),
		.isAlt1(isAlt1), .isAlt2(isAlt2)
	);

	gameChecker outputCheck (
		.VGA_VS(VGA_VS), .rstN(rstN), .keycode(keycode), .PS2keycode(PS2keycode),
		.xOne(xOne), .yOne(yOne), .xTwo(xTwo), .yTwo(yTwo),
		.p1dir(p1dir), .p2dir(p2dir), .currState(currState),
		.isAlt1(isAlt1), .isAlt2(isAlt2),
		.errorCount(errorCount), .checkCount(checkCount)
	);

	initial
	begin
		VGA_VS = 1'b0;
		forever #(clockPeriod / 2) VGA_VS = ~VGA_VS;
	end

	task automatic holdKeys(
		input logic [keycodeWidth-1:0] wordOne,
		input logic [keycodeWidth-1:0] wordTwo,
		input int cycles
	);
		repeat (cycles)
		begin
			@(posedge VGA_VS);
			keycode <= wordOne;
			PS2keycode <= wordTwo;
		end
	endtask

	task automatic applyReset();
		repeat (resetCycles)
		begin
			@(posedge VGA_VS);
			rstN <= 1'b0;
			keycode <= '0;
			PS2keycode <= '0;
		end
		@(posedge VGA_VS);
		rstN <= 1'b1;
	endtask

	// Each slot gets a move or aim key, or stays empty
	task automatic randomWord(input int player, output logic [keycodeWidth-1:0] word);
		int pick;
		word = '0;
		for (int i = 0; i < rolloverKeys; i++)
		begin
			pick = $unsigned($random(seed)) % 14;
			if (pick < 8)
				word[i*keyWidth +: keyWidth] = (player == 0) ? usbKeys[pick] : ps2Keys[pick];
		end
	endtask

	task automatic randomPlay(input int cycles);
		logic [keycodeWidth-1:0] wordOne;
		logic [keycodeWidth-1:0] wordTwo;
		repeat (cycles)
		begin
			randomWord(0, wordOne);
			randomWord(1, wordTwo);
			holdKeys(wordOne, wordTwo, 1);
		end
	endtask

	// First ENTER, a pause, then the other player's ENTER
	task automatic startMatch(input logic twoFirst);
		logic [keycodeWidth-1:0] enterOne;
		logic [keycodeWidth-1:0] enterTwo;
		enterOne = {24'h0, keyEnterUsb};
		enterTwo = {keyEnterPs2, 24'h0};
		holdKeys(twoFirst ? '0 : enterOne, twoFirst ? enterTwo : '0, 2);
		holdKeys('0, '0, 3);
		holdKeys(twoFirst ? enterOne : '0, twoFirst ? '0 : enterTwo, 2);
		holdKeys('0, '0, 5);
	endtask

	initial
	begin
		seed = 32'h5134_eb47;
		rstN <= 1'b0;
		keycode <= '0;
		PS2keycode <= '0;
		applyReset();
		// Keys before play must leave everyone in place
		randomPlay(preCycles);
		startMatch(1'b1);
		randomPlay(randomCycles);
		// Opposite corners
		holdKeys({16'h0, keyW, keyA}, {16'h0, keyDPs2, keySPs2}, clampCycles);
		applyReset();
		startMatch(1'b0);
		// Close the x gap until it equals the y gap
		holdKeys({24'h0, keyD}, {24'h0, keyAPs2}, alignCycles);
		// Head on until the separation rule stops both
		holdKeys({16'h0, keyS, keyD}, {16'h0, keyWPs2, keyAPs2}, meetCycles);
		randomPlay(randomCycles);
		holdKeys('0, '0, idleCycles);
		@(posedge VGA_VS);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#((totalCycles + marginCycles) * clockPeriod);
		$display("Run timed out after %0d cycles", totalCycles + marginCycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
